// ==== all.f ====
+incdir+dv
source/stream_fmt_pkg.sv
source/buffer_cfg_pkg.sv
source/chaos_lfsr.sv
source/sync_fifo.sv
source/byte_packer.sv
source/byte_unpacker.sv
source/byte_buffer_top.sv
dv/byte_buffer_tb.sv

// ==== dv/byte_buffer_model.svh ====
// Reference model of the elastic buffer, included inside the testbench module.
// A byte queue in arrival order. The testbench pushes each byte the DUT
// accepted and pops one for each byte the DUT hands out.

`ifndef BYTE_BUFFER_MODEL_SVH
`define BYTE_BUFFER_MODEL_SVH

logic [byte_w-1:0] byte_q [$];   // bytes in flight, oldest first
int byte_total;                  // bytes accepted since reset
int words_total;                 // whole words accepted
int last_word_edge;              // edge number that completed the last word

// byte taken at the input on edge edge_no
function automatic void record_byte(input logic [byte_w-1:0] b, input int edge_no);
   begin
      byte_q.push_back(b);
      byte_total = byte_total + 1;
      // fourth byte closes a word
      if ((byte_total % bytes_per_word) == 0)
      begin
         words_total    = words_total + 1;
         last_word_edge = edge_no;
      end
   end
endfunction

// oldest byte, removed from the queue
// caller makes sure the queue is not empty
function automatic logic [byte_w-1:0] take_expected();
   logic [byte_w-1:0] b;
   begin
      b = byte_q.pop_front();
      return b;
   end
endfunction

`endif

// ==== dv/byte_buffer_tb.sv ====
// Testbench for the byte-stream elastic buffer.
// Seeded random traffic with and without chaos mode, a storage limit run
// and a latency run. A byte queue model checks every byte at the output.

`timescale 1ns/1ps

module byte_buffer_tb
   import stream_fmt_pkg::*;
;

   localparam int depth = 4;             // FIFO words in the DUT
   localparam int latency_edges = 3;     // push, FIFO write, unpacker load

   // phase lengths in cycles
   localparam int reset_cycles    = 3;
   localparam int transfer_cycles = 1500;
   localparam int fill_cycles     = 100;
   localparam int chaos_cycles    = 2000;
   localparam int latency_cycles  = 50;
   localparam int drain_cycles    = 200;   // for each of the four drains
   localparam int phase_sum = reset_cycles + transfer_cycles + fill_cycles +
                              chaos_cycles + latency_cycles + 4 * drain_cycles;
   localparam int timeout_limit = 2 * phase_sum;

   logic              clk;
   logic              nreset;
   logic              chaos_mode;
   logic              in_valid;
   logic [byte_w-1:0] in_byte;
   logic              in_full;
   logic              out_valid;
   logic [byte_w-1:0] out_byte;
   logic              out_take;

   integer seed = 32'h9a10;   // fixed seed for $random
   int cycle_count;           // rising edges so far
   int chaos_hits;            // in_full seen with room in the FIFO
   int valid_rise_edge;       // edge where out_valid was first seen high
   logic out_seen;            // out_valid on the previous edge

   `include "byte_buffer_model.svh"

   byte_buffer_top #(
      .DEPTH (depth),
      .CHAOS (1)
   ) uut
   (
      .clk        (clk),
      .nreset     (nreset),
      .chaos_mode (chaos_mode),
      .in_valid   (in_valid),
      .in_byte    (in_byte),
      .in_full    (in_full),
      .out_valid  (out_valid),
      .out_byte   (out_byte),
      .out_take   (out_take)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   //############################################################
   // helpers
   //############################################################

   task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                              input string what);
      begin
         if (expected !== actual)
         begin
            $display("[FAIL] %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
         end
      end
   endtask

   function automatic logic [byte_w-1:0] random_byte();
      logic [31:0] r;
      begin
         r = $random(seed);
         return r[byte_w-1:0];
      end
   endfunction

   // true in about pct percent of calls
   function automatic logic percent_chance(input int pct);
      logic [31:0] r;
      begin
         r = $random(seed);
         return (r % 100) < pct;
      end
   endfunction

   //############################################################
   // port sampling and model update
   //############################################################

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (nreset)
      begin
         // with a word pending this many bytes leave the FIFO short of full
         if (chaos_mode && in_full && (byte_q.size() <= bytes_per_word * depth))
            chaos_hits = chaos_hits + 1;
         if (out_valid && !out_seen)
            valid_rise_edge = cycle_count;
         out_seen = out_valid;
         if (in_valid && !in_full)
            record_byte(in_byte, cycle_count);   // refused bytes skipped
         if (out_valid && out_take)
         begin
            if (byte_q.size() == 0)
            begin
               $display("output handed out a byte while the model expected none");
               $display("CHECKS FAILED");
               $fatal(1, "unexpected output byte");
            end
            else
               check_value(take_expected(), out_byte, "byte order at output");
         end
      end
   end

   always @(negedge clk)
   begin
      if (cycle_count >= timeout_limit)
      begin
         $display("run timed out after %0d cycles", timeout_limit);
         $display("CHECKS FAILED");
         $fatal(1, "timeout");
      end
   end

   //############################################################
   // stimulus tasks start and end on a falling edge
   //############################################################

   task automatic run_random_traffic(input int cycles, input logic chaos,
                                     input int pct_in, input int pct_out);
      begin
         repeat (cycles)
         begin
            chaos_mode = chaos;
            in_valid   = percent_chance(pct_in);
            in_byte    = random_byte();
            out_take   = percent_chance(pct_out);
            @(negedge clk);
         end
         in_valid = 1'b0;
         out_take = 1'b0;
      end
   endtask

   // top up a half-built word so the path can drain
   task automatic finish_partial_word;
      begin
         out_take = 1'b1;
         while ((byte_total % bytes_per_word) != 0)
         begin
            in_valid = 1'b1;
            in_byte  = random_byte();
            @(negedge clk);
         end
         in_valid = 1'b0;
      end
   endtask

   task automatic empty_path;
      begin
         chaos_mode = 1'b0;
         finish_partial_word();
         in_valid = 1'b0;
         out_take = 1'b1;
         while (byte_q.size() != 0)
            @(negedge clk);
         out_take = 1'b0;
      end
   endtask

   // fill with no takes until in_full holds and keep offering
   task automatic check_storage_limit;
      int start_words;
      int full_run;
      begin
         start_words = words_total;
         full_run    = 0;
         out_take    = 1'b0;
         while (full_run < 8)
         begin
            in_valid = 1'b1;
            in_byte  = random_byte();
            @(negedge clk);
            full_run = in_full ? full_run + 1 : 0;
         end
         check_value(depth + 2, words_total - start_words, "words stored at in_full");
         repeat (16)
         begin
            in_byte = random_byte();   // offered while full
            @(negedge clk);
            check_value(1, in_full, "in_full held under back-pressure");
         end
         in_valid = 1'b0;
      end
   endtask

   // edges from one word into an empty path to out_valid
   task automatic measure_latency;
      int latency;
      begin
         chaos_mode = 1'b0;
         out_take   = 1'b0;
         repeat (bytes_per_word)
         begin
            in_valid = 1'b1;
            in_byte  = random_byte();
            @(negedge clk);
         end
         in_valid = 1'b0;
         while (valid_rise_edge <= last_word_edge)
            @(negedge clk);
         latency = valid_rise_edge - last_word_edge;
         check_value(latency_edges, latency, "edges from last byte to out_valid");
      end
   endtask

   //############################################################
   // test sequence
   //############################################################

   initial
   begin
      nreset     = 1'b0;
      chaos_mode = 1'b0;
      in_valid   = 1'b0;
      in_byte    = '0;
      out_take   = 1'b0;
      out_seen   = 1'b0;

      repeat (reset_cycles)
      begin
         @(negedge clk);
         check_value(0, in_full, "in_full during reset");
         check_value(0, out_valid, "out_valid during reset");
      end
      nreset = 1'b1;
      @(negedge clk);
      check_value(0, in_full, "in_full after reset");
      check_value(0, out_valid, "out_valid after reset");

      run_random_traffic(transfer_cycles, 1'b0, 60, 60);   // ordered transfer
      empty_path();
      check_storage_limit();
      empty_path();                                         // returns stored words in order
      run_random_traffic(chaos_cycles, 1'b1, 100, 60);     // steady input against random full
      check_value(1, chaos_hits != 0, "in_full from chaos with FIFO room");
      empty_path();
      measure_latency();
      empty_path();

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule : byte_buffer_tb

// ==== source/byte_buffer_top.sv ====
// Top level of the byte-stream elastic buffer.
// Bytes enter through the packer, travel as words through the FIFO and
// leave one at a time through the unpacker. DEPTH and CHAOS are set here
// and go down to the FIFO. chaos_mode turns the random full on at run time.

`timescale 1ns/1ps

module byte_buffer_top
   import stream_fmt_pkg::*;
   import buffer_cfg_pkg::*;
#(
   parameter int DEPTH = default_depth,   // FIFO words, power of two
   parameter int CHAOS = 1                // build the random-full lfsr
)
(
   input  logic              clk,
   input  logic              nreset,
   input  logic              chaos_mode,
   // byte input
   input  logic              in_valid,
   input  logic [byte_w-1:0] in_byte,
   output logic              in_full,
   // byte output
   output logic              out_valid,
   output logic [byte_w-1:0] out_byte,
   input  logic              out_take
);

   // packer to FIFO
   logic              wr_en;
   logic [word_w-1:0] wr_din;
   logic              wr_full;
   // FIFO to unpacker
   logic              rd_en;
   logic [word_w-1:0] rd_dout;
   logic              rd_empty;

   // input side
   byte_packer u_packer
   (
      .clk      (clk),
      .nreset   (nreset),
      .in_valid (in_valid),
      .in_byte  (in_byte),
      .in_full  (in_full),
      .wr_en    (wr_en),
      .wr_din   (wr_din),
      .wr_full  (wr_full)
   );

   // word storage
   sync_fifo #(
      .DEPTH (DEPTH),
      .CHAOS (CHAOS)
   ) u_fifo
   (
      .clk        (clk),
      .nreset     (nreset),
      .chaos_mode (chaos_mode),
      .wr_en      (wr_en),
      .wr_din     (wr_din),
      .wr_full    (wr_full),
      .rd_en      (rd_en),
      .rd_dout    (rd_dout),
      .rd_empty   (rd_empty)
   );

   // output side
   byte_unpacker u_unpacker
   (
      .clk       (clk),
      .nreset    (nreset),
      .rd_en     (rd_en),
      .rd_dout   (rd_dout),
      .rd_empty  (rd_empty),
      .out_valid (out_valid),
      .out_byte  (out_byte),
      .out_take  (out_take)
   );

endmodule : byte_buffer_top

// ==== source/byte_unpacker.sv ====
// Output side of the buffer.
// Loads one word from the FIFO head into a holding register when the
// register is empty, then shows its bytes in order starting with byte 0.
// Each out_take moves to the next byte. The take on the last byte
// empties the register.

`timescale 1ns/1ps

module byte_unpacker
   import stream_fmt_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   // FIFO read port
   output logic              rd_en,
   input  logic [word_w-1:0] rd_dout,    // head word
   input  logic              rd_empty,
   // byte consumer
   output logic              out_valid,  // level
   output logic [byte_w-1:0] out_byte,
   input  logic              out_take    // one-cycle pulse
);

   logic              held;        // holding register has a word
   logic [1:0]        idx;         // byte shown on out_byte
   logic [word_w-1:0] hold_word;
   logic              take;        // byte handed out this cycle

   //############################################################
   // load and take
   //############################################################

   // no reload on the edge of the last take
   // a new word waits for the following edge
   assign rd_en = ~held & ~rd_empty;
   assign take  = out_take & held;   // stray takes do nothing

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         held <= 1'b0;
         idx  <= 2'd0;
      end
      else if (rd_en)
      begin
         held <= 1'b1;
         idx  <= 2'd0;            // start at the first byte received
      end
      else if (take)
      begin
         idx <= idx + 2'd1;
         if (idx == last_byte)
            held <= 1'b0;         // word used up
      end
   end

   // payload only, follows the load
   always_ff @(posedge clk)
   begin
      if (rd_en)
         hold_word <= rd_dout;
   end

   //############################################################
   // byte select
   //############################################################

   assign out_valid = held;
   assign out_byte  = hold_word[idx*byte_w +: byte_w];   // low byte first

endmodule : byte_unpacker

// ==== source/byte_packer.sv ====
// Input side of the buffer.
// Gathers accepted bytes into a word, low byte first, and pushes each full
// word into the FIFO. A finished word waits as pending until the FIFO
// takes it. in_full goes high while it waits on a full FIFO.

`timescale 1ns/1ps

module byte_packer
   import stream_fmt_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   // byte source
   input  logic              in_valid,   // one-cycle strobe per byte
   input  logic [byte_w-1:0] in_byte,
   output logic              in_full,    // bytes are dropped while high
   // FIFO write port
   output logic              wr_en,
   output logic [word_w-1:0] wr_din,
   input  logic              wr_full
);

   logic [1:0]        cnt;         // bytes held so far
   logic              pending;     // complete word waiting for the FIFO
   logic [word_w-1:0] asm_word;    // assembly register
   logic              accept;      // byte taken this cycle
   logic              push;        // pending word written this cycle

   //############################################################
   // handshake terms
   //############################################################

   assign in_full = pending & wr_full;
   assign accept  = in_valid & ~in_full;
   assign push    = pending & ~wr_full;   // packer is free again on this edge

   assign wr_en  = pending;
   assign wr_din = asm_word;

   //############################################################
   // control
   //############################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         cnt     <= 2'd0;
         pending <= 1'b0;
      end
      else
      begin
         if (accept)
            cnt <= cnt + 2'd1;   // wraps to zero after the last byte

         // the two cases never meet, cnt is zero while pending
         if (accept && (cnt == last_byte))
            pending <= 1'b1;
         else if (push)
            pending <= 1'b0;
      end
   end

   // new bytes enter at the top and move down
   // after four bytes the first one sits in the low byte
   // a byte taken during a push lands after the old word is written
   always_ff @(posedge clk)
   begin
      if (accept)
         asm_word <= {in_byte, asm_word[word_w-1:byte_w]};
   end

endmodule : byte_packer

// ==== source/sync_fifo.sv ====
// Single-clock word FIFO between the packer and the unpacker.
// Pointers carry one extra bit to tell full from empty. The head word is
// shown on rd_dout without a register. With CHAOS set and chaos_mode high
// wr_full is also raised at pseudo-random times, which blocks writes only.

`timescale 1ns/1ps

module sync_fifo
   import stream_fmt_pkg::*;
   import buffer_cfg_pkg::*;
#(
   parameter int DEPTH = default_depth,   // words, power of two
   parameter int CHAOS = 1                // 1 builds the lfsr
)
(
   input  logic              clk,
   input  logic              nreset,
   input  logic              chaos_mode,   // level, enables fake full
   // write side
   input  logic              wr_en,
   input  logic [word_w-1:0] wr_din,
   output logic              wr_full,
   // read side
   input  logic              rd_en,
   output logic [word_w-1:0] rd_dout,      // head word, combinational
   output logic              rd_empty
);

   localparam int addr_w = $clog2(DEPTH);

   logic [addr_w:0]   wr_ptr;      // msb is the wrap bit
   logic [addr_w:0]   rd_ptr;
   logic              true_full;
   logic              chaos_bit;
   logic              do_write;    // accepted write this cycle
   logic              do_read;     // accepted pop this cycle
   logic [word_w-1:0] mem [DEPTH];

   //############################################################
   // random full
   //############################################################

   generate
      if (CHAOS == 1)
      begin : g_chaos
         chaos_lfsr u_lfsr
         (
            .clk       (clk),
            .nreset    (nreset),
            .chaos_bit (chaos_bit)
         );
      end
      else
      begin : g_no_chaos
         assign chaos_bit = 1'b0;   // no lfsr built
      end
   endgenerate

   //############################################################
   // status
   //############################################################

   // same address, different wrap bit
   assign true_full = (wr_ptr == {~rd_ptr[addr_w], rd_ptr[addr_w-1:0]});
   assign rd_empty  = (wr_ptr == rd_ptr);
   assign wr_full   = true_full | (chaos_mode & chaos_bit);

   assign do_write = wr_en & ~wr_full;
   assign do_read  = rd_en & ~rd_empty;   // fake full never stalls reads

   //############################################################
   // pointers and storage
   //############################################################

   // each pointer moves on its own
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_write)
         mem[wr_ptr[addr_w-1:0]] <= wr_din;
   end

   assign rd_dout = mem[rd_ptr[addr_w-1:0]];   // visible one edge after write

endmodule : sync_fifo

// ==== source/chaos_lfsr.sv ====
// Pseudo-random source for the FIFO chaos mode.
// A free-running Galois LFSR. Its low bit serves as a fake full request,
// true about half the time in an irregular pattern.

`timescale 1ns/1ps

module chaos_lfsr
   import buffer_cfg_pkg::*;
(
   input  logic clk,
   input  logic nreset,
   output logic chaos_bit   // fake full request
);

   logic [lfsr_w-1:0] lfsr;       // state, never all zero
   logic [lfsr_w-1:0] lfsr_nxt;

   // shift right and fold the taps back in when a one drops out
   always_comb
   begin
      lfsr_nxt = lfsr >> 1;
      if (lfsr[0])
      begin
         lfsr_nxt = lfsr_nxt ^ lfsr_taps;
      end
   end

   // advances every cycle, no enable
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         lfsr <= lfsr_seed;
      end
      else
      begin
         lfsr <= lfsr_nxt;
      end
   end

   assign chaos_bit = lfsr[0];   // low bit is the output

endmodule : chaos_lfsr

// ==== source/buffer_cfg_pkg.sv ====
// Configuration of the elastic buffer.
// Holds the chaos LFSR polynomial and seed and the default FIFO depth.
// The top level takes its depth default from here.

package buffer_cfg_pkg;

   //############################################################
   // chaos LFSR
   //############################################################

   localparam int lfsr_w = 16;

   // galois mask for x^16 + x^14 + x^13 + x^11 + 1 (maximal length)
   localparam logic [lfsr_w-1:0] lfsr_taps = 16'hb400;

   // any nonzero start value works
   localparam logic [lfsr_w-1:0] lfsr_seed = 16'hace1;

   //############################################################
   // FIFO
   //############################################################

   localparam int default_depth = 4;   // words, power of two

endpackage : buffer_cfg_pkg

// ==== source/stream_fmt_pkg.sv ====
// Data format of the byte stream and of the words stored in the FIFO.
// Import it wherever a byte or a word crosses a port.
// Four bytes make one word, and the first byte received sits in the low byte.

package stream_fmt_pkg;

   // one stream byte as seen on in_byte / out_byte
   localparam int byte_w = 8;

   // bytes gathered into one FIFO word
   localparam int bytes_per_word = 4;

   // FIFO word width
   localparam int word_w = byte_w * bytes_per_word;   // 32 bits

   // index of the last byte in a word
   // packer and unpacker use it to spot the word boundary
   localparam logic [1:0] last_byte = 2'(bytes_per_word - 1);

endpackage : stream_fmt_pkg
